// File: Makefile
SRCS := $(shell cat mesh_array.f)
BIN  := obj_dir/Vmesh_array_tb

.PHONY: all run clean

all: run

$(BIN): mesh_array.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f mesh_array.f \
		--top-module mesh_array_tb -o Vmesh_array_tb

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q '\*\*\* TEST PASSED \*\*\*' sim.log

clean:
	rm -rf obj_dir sim.log

// File: mesh_array.f
source/mesh_pkg.sv
source/mesh_router.sv
source/mesh_tile_mem.sv
source/mesh_array.sv
test/mesh_array_tb.sv

// File: source/mesh_array.sv
//======================================================================
// 2d mesh of tiles with a host io row
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module mesh_array (
  input  logic                                             clk,
  input  logic                                             arst_n_i,
  input  mesh_pkg::mesh_link_s [mesh_pkg::num_tiles_x-1:0] io_link_i,
  output logic                 [mesh_pkg::num_tiles_x-1:0] io_ready_o,
  output mesh_pkg::mesh_link_s [mesh_pkg::num_tiles_x-1:0] io_link_o,
  input  logic                 [mesh_pkg::num_tiles_x-1:0] io_ready_i
);

  localparam int nx = mesh_pkg::num_tiles_x;
  localparam int ny = mesh_pkg::num_tiles_y;

  // per router port bundles, indexed [y][x][dir]
  mesh_pkg::mesh_link_s [mesh_pkg::num_dirs-1:0] rtr_link_in   [ny][nx];
  mesh_pkg::mesh_link_s [mesh_pkg::num_dirs-1:0] rtr_link_out  [ny][nx];
  mesh_pkg::dir_vec_t                            rtr_ready_in  [ny][nx];
  mesh_pkg::dir_vec_t                            rtr_ready_out [ny][nx];

  for (genvar gy = 0; gy < ny; gy++) begin : g_row
    for (genvar gx = 0; gx < nx; gx++) begin : g_col

      mesh_router #(
        .my_x(mesh_pkg::x_cord_t'(gx)),
        .my_y(mesh_pkg::y_cord_t'(gy))
      ) u_router (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .link_i   (rtr_link_in[gy][gx]),
        .ready_o  (rtr_ready_out[gy][gx]),
        .link_o   (rtr_link_out[gy][gx]),
        .ready_i  (rtr_ready_in[gy][gx])
      );

      mesh_tile_mem #(
        .my_x(mesh_pkg::x_cord_t'(gx)),
        .my_y(mesh_pkg::y_cord_t'(gy))
      ) u_mem (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_i        (rtr_link_out[gy][gx][mesh_pkg::P]),
        .req_ready_o  (rtr_ready_in[gy][gx][mesh_pkg::P]),
        .resp_o       (rtr_link_in[gy][gx][mesh_pkg::P]),
        .resp_ready_i (rtr_ready_out[gy][gx][mesh_pkg::P])
      );

      // west side
      if (gx == 0) begin : g_w_edge
        assign rtr_link_in[gy][gx][mesh_pkg::W]  = '0; // never valid
        assign rtr_ready_in[gy][gx][mesh_pkg::W] = 1'b1;
      end else begin : g_w_link
        assign rtr_link_in[gy][gx][mesh_pkg::W]  = rtr_link_out[gy][gx-1][mesh_pkg::E];
        assign rtr_ready_in[gy][gx][mesh_pkg::W] = rtr_ready_out[gy][gx-1][mesh_pkg::E];
      end

      // east side
      if (gx == nx - 1) begin : g_e_edge
        assign rtr_link_in[gy][gx][mesh_pkg::E]  = '0;
        assign rtr_ready_in[gy][gx][mesh_pkg::E] = 1'b1;
      end else begin : g_e_link
        assign rtr_link_in[gy][gx][mesh_pkg::E]  = rtr_link_out[gy][gx+1][mesh_pkg::W];
        assign rtr_ready_in[gy][gx][mesh_pkg::E] = rtr_ready_out[gy][gx+1][mesh_pkg::W];
      end

      // north side
      if (gy == 0) begin : g_n_edge
        assign rtr_link_in[gy][gx][mesh_pkg::N]  = '0;
        assign rtr_ready_in[gy][gx][mesh_pkg::N] = 1'b1;
      end else begin : g_n_link
        assign rtr_link_in[gy][gx][mesh_pkg::N]  = rtr_link_out[gy-1][gx][mesh_pkg::S];
        assign rtr_ready_in[gy][gx][mesh_pkg::N] = rtr_ready_out[gy-1][gx][mesh_pkg::S];
      end

      // south side, bottom row faces the host
      if (gy == ny - 1) begin : g_s_io
        assign rtr_link_in[gy][gx][mesh_pkg::S]  = io_link_i[gx];
        assign rtr_ready_in[gy][gx][mesh_pkg::S] = io_ready_i[gx];
        assign io_link_o[gx]                     = rtr_link_out[gy][gx][mesh_pkg::S];
        assign io_ready_o[gx]                    = rtr_ready_out[gy][gx][mesh_pkg::S];
      end else begin : g_s_link
        assign rtr_link_in[gy][gx][mesh_pkg::S]  = rtr_link_out[gy+1][gx][mesh_pkg::N];
        assign rtr_ready_in[gy][gx][mesh_pkg::S] = rtr_ready_out[gy+1][gx][mesh_pkg::N];
      end

    end
  end

endmodule

`default_nettype wire

// File: source/mesh_pkg.sv
//======================================================================
// mesh noc shared types
//======================================================================
`default_nettype none

package mesh_pkg;

  // grid size, fixed for the whole build
  localparam int num_tiles_x = 2;
  localparam int num_tiles_y = 2;
  localparam int io_row      = num_tiles_y; // host row just south of the grid

  localparam int num_dirs  = 5;
  localparam int mem_words = 256;

  typedef logic [0:0]  x_cord_t;
  typedef logic [1:0]  y_cord_t;  // wide enough for io_row
  typedef logic [7:0]  addr_t;    // word address inside one tile
  typedef logic [31:0] data_t;

  typedef logic [num_dirs-1:0] dir_vec_t; // one bit per router port
  typedef logic [2:0]          dir_idx_t; // port number, used by the arbiters

  typedef enum logic [1:0] {
    op_store = 2'd0,
    op_load  = 2'd1,
    op_resp  = 2'd2  // load data on its way back
  } pkt_op_e;

  // port numbering of every router
  typedef enum logic [2:0] {
    P = 3'd0,
    W = 3'd1,
    E = 3'd2,
    N = 3'd3,
    S = 3'd4
  } dir_e;

  typedef struct packed {
    pkt_op_e op;
    x_cord_t dest_x;
    y_cord_t dest_y;
    x_cord_t src_x;  // where a response goes back to
    y_cord_t src_y;
    addr_t   addr;
    data_t   data;
  } mesh_pkt_s;

  // forward half of a link, ready runs the other way
  typedef struct packed {
    logic      valid;
    mesh_pkt_s pkt;
  } mesh_link_s;

endpackage

`default_nettype wire

// File: source/mesh_router.sv
//======================================================================
// five-port dimension-order mesh router
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module mesh_router #(
  parameter mesh_pkg::x_cord_t my_x = '0,
  parameter mesh_pkg::y_cord_t my_y = '0
) (
  input  logic                                          clk,
  input  logic                                          arst_n_i,
  input  mesh_pkg::mesh_link_s [mesh_pkg::num_dirs-1:0] link_i,
  output mesh_pkg::dir_vec_t                            ready_o,
  output mesh_pkg::mesh_link_s [mesh_pkg::num_dirs-1:0] link_o,
  input  mesh_pkg::dir_vec_t                            ready_i
);

  mesh_pkg::mesh_pkt_s [mesh_pkg::num_dirs-1:0] buf_pkt_q;
  mesh_pkg::dir_vec_t                           buf_valid_q;

  mesh_pkg::dir_e     route     [mesh_pkg::num_dirs];
  mesh_pkg::dir_vec_t req       [mesh_pkg::num_dirs]; // req[out][in]
  mesh_pkg::dir_vec_t grant_vld;
  mesh_pkg::dir_idx_t grant_idx [mesh_pkg::num_dirs];
  mesh_pkg::dir_idx_t last_q    [mesh_pkg::num_dirs];
  mesh_pkg::dir_vec_t pop;

  // x first, then y, then deliver locally
  function automatic mesh_pkg::dir_e route_of(mesh_pkg::mesh_pkt_s pkt);
    mesh_pkg::dir_e dir;
    if (pkt.dest_x > my_x) dir = mesh_pkg::E;
    else if (pkt.dest_x < my_x) dir = mesh_pkg::W;
    else if (pkt.dest_y > my_y) dir = mesh_pkg::S;
    else if (pkt.dest_y < my_y) dir = mesh_pkg::N;
    else dir = mesh_pkg::P;
    return dir;
  endfunction

  always_comb begin
    for (int i = 0; i < mesh_pkg::num_dirs; i++) begin
      route[i] = route_of(buf_pkt_q[i]);
    end
  end

  always_comb begin
    for (int o = 0; o < mesh_pkg::num_dirs; o++) begin
      for (int i = 0; i < mesh_pkg::num_dirs; i++) begin
        req[o][i] = buf_valid_q[i] && (int'(route[i]) == o);
      end
    end
  end

  // round robin per output, search starts after the last winner
  always_comb begin
    int cand;
    cand      = 0;
    grant_vld = '0;
    pop       = '0;
    for (int o = 0; o < mesh_pkg::num_dirs; o++) begin
      grant_idx[o] = last_q[o];
      for (int k = 1; k <= mesh_pkg::num_dirs; k++) begin
        cand = int'(last_q[o]) + k;
        if (cand >= mesh_pkg::num_dirs) cand = cand - mesh_pkg::num_dirs;
        if (!grant_vld[o] && req[o][cand]) begin
          grant_vld[o] = 1'b1;
          grant_idx[o] = mesh_pkg::dir_idx_t'(cand);
        end
      end
      if (grant_vld[o] && ready_i[o]) pop[grant_idx[o]] = 1'b1;
    end
  end

  always_comb begin
    for (int o = 0; o < mesh_pkg::num_dirs; o++) begin
      link_o[o].valid = grant_vld[o];
      link_o[o].pkt   = buf_pkt_q[grant_idx[o]];
    end
  end

  assign ready_o = ~buf_valid_q | pop; // empty, or draining this edge

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_valid_q <= '0;
      for (int o = 0; o < mesh_pkg::num_dirs; o++) begin
        last_q[o] <= mesh_pkg::dir_idx_t'(mesh_pkg::num_dirs - 1); // P wins first
      end
    end else begin
      for (int i = 0; i < mesh_pkg::num_dirs; i++) begin
        if (ready_o[i]) buf_valid_q[i] <= link_i[i].valid;
      end
      for (int o = 0; o < mesh_pkg::num_dirs; o++) begin
        if (grant_vld[o] && ready_i[o]) begin
          last_q[o] <= grant_idx[o];
        end else if (grant_vld[o]) begin
          // a stalled winner is searched first next cycle
          last_q[o] <= (grant_idx[o] == '0) ? mesh_pkg::dir_idx_t'(mesh_pkg::num_dirs - 1)
                                           : grant_idx[o] - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < mesh_pkg::num_dirs; i++) begin
      if (ready_o[i] && link_i[i].valid) buf_pkt_q[i] <= link_i[i].pkt;
    end
  end

  for (genvar d = 0; d < mesh_pkg::num_dirs; d++) begin : g_chk
    // an offered packet stays put until the next hop takes it
    a_hold_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
      link_o[d].valid && !ready_i[d] |=> link_o[d].valid && $stable(link_o[d].pkt));

    // S off the bottom row is the host row, every other edge is a dead end
    a_route_in_grid: assert property (@(posedge clk) disable iff (!arst_n_i)
      buf_valid_q[d] |->
        !((route[d] == mesh_pkg::W && my_x == '0) ||
          (route[d] == mesh_pkg::E && int'(my_x) == mesh_pkg::num_tiles_x - 1) ||
          (route[d] == mesh_pkg::N && my_y == '0)));
  end

endmodule

`default_nettype wire

// File: source/mesh_tile_mem.sv
//======================================================================
// tile word memory endpoint
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module mesh_tile_mem #(
  parameter mesh_pkg::x_cord_t my_x = '0,
  parameter mesh_pkg::y_cord_t my_y = '0
) (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  mesh_pkg::mesh_link_s req_i,
  output logic                 req_ready_o,
  output mesh_pkg::mesh_link_s resp_o,
  input  logic                 resp_ready_i
);

  mesh_pkg::data_t     mem_q [mesh_pkg::mem_words];
  mesh_pkg::mesh_pkt_s resp_pkt_q;
  logic                resp_valid_q;
  logic                req_fire;

  // stalls everything while a response waits, stores included
  assign req_ready_o = !resp_valid_q;
  assign req_fire    = req_i.valid && req_ready_o;

  always_ff @(posedge clk) begin
    if (req_fire && req_i.pkt.op == mesh_pkg::op_store) begin
      mem_q[req_i.pkt.addr] <= req_i.pkt.data;
    end
  end

  // response heads back to whoever asked
  always_ff @(posedge clk) begin
    if (req_fire && req_i.pkt.op == mesh_pkg::op_load) begin
      resp_pkt_q.op     <= mesh_pkg::op_resp;
      resp_pkt_q.dest_x <= req_i.pkt.src_x;
      resp_pkt_q.dest_y <= req_i.pkt.src_y;
      resp_pkt_q.src_x  <= my_x;
      resp_pkt_q.src_y  <= my_y;
      resp_pkt_q.addr   <= req_i.pkt.addr;
      resp_pkt_q.data   <= mem_q[req_i.pkt.addr];
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire && req_i.pkt.op == mesh_pkg::op_load) begin
      resp_valid_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_valid_q <= 1'b0; // taken by the router
    end
  end

  assign resp_o.valid = resp_valid_q;
  assign resp_o.pkt   = resp_pkt_q;

  // routing upstream must only deliver packets meant for this tile
  a_dest_match: assert property (@(posedge clk) disable iff (!arst_n_i)
    req_fire |-> req_i.pkt.dest_x == my_x && req_i.pkt.dest_y == my_y);

  a_no_resp_in: assert property (@(posedge clk) disable iff (!arst_n_i)
    req_fire |-> req_i.pkt.op != mesh_pkg::op_resp);

endmodule

`default_nettype wire

// File: test/mesh_array_tb.sv
//======================================================================
// mesh noc directed testbench
//======================================================================
`timescale 1ns/1ps
`default_nettype none

module mesh_array_tb;

  localparam int nx         = mesh_pkg::num_tiles_x;
  localparam int num_random = 200;
  localparam int num_pkts   = 18 + num_random; // directed plus random packets
  localparam int max_cycles = num_pkts * 19;  // generous bound per packet
  localparam int wait_limit = 200;            // per handshake

  logic                            clk = 1'b0;
  logic                            arst_n_i;
  mesh_pkg::mesh_link_s [nx-1:0]   io_link_i;
  logic                 [nx-1:0]   io_ready_o;
  mesh_pkg::mesh_link_s [nx-1:0]   io_link_o;
  logic                 [nx-1:0]   io_ready_i;

  mesh_pkg::mesh_pkt_s rx_q [nx][$]; // responses seen per column
  mesh_pkg::data_t     ref_mem [int];
  int errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycles = 0;

  mesh_array uut (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .io_link_i  (io_link_i),
    .io_ready_o (io_ready_o),
    .io_link_o  (io_link_o),
    .io_ready_i (io_ready_i)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("run stopped: no end after %0d cycles", max_cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // between edges nothing moves, so a valid and ready pair here transfers next edge
  always @(negedge clk) begin
    for (int c = 0; c < nx; c++) begin
      if (arst_n_i && io_link_o[c].valid && io_ready_i[c]) rx_q[c].push_back(io_link_o[c].pkt);
    end
  end

  function automatic mesh_pkg::mesh_pkt_s make_pkt(mesh_pkg::pkt_op_e op, int col, int tx,
                                                   int ty, mesh_pkg::addr_t addr,
                                                   mesh_pkg::data_t data);
    mesh_pkg::mesh_pkt_s pkt;
    pkt.op     = op;
    pkt.dest_x = mesh_pkg::x_cord_t'(tx);
    pkt.dest_y = mesh_pkg::y_cord_t'(ty);
    pkt.src_x  = mesh_pkg::x_cord_t'(col);
    pkt.src_y  = mesh_pkg::y_cord_t'(mesh_pkg::io_row); // host sits below the grid
    pkt.addr   = addr;
    pkt.data   = data;
    return pkt;
  endfunction

  function automatic int mem_key(int tx, int ty, mesh_pkg::addr_t addr);
    return (ty * nx + tx) * mesh_pkg::mem_words + int'(addr);
  endfunction

  task send_pkt(input int col, input mesh_pkg::mesh_pkt_s pkt);
    int waited;
    waited = 0;
    @(posedge clk);
    io_link_i[col] <= {1'b1, pkt};
    @(negedge clk);
    while (!io_ready_o[col] && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    if (!io_ready_o[col]) begin
      $display("column %0d input stayed busy for %0d cycles", col, wait_limit);
      errors++;
    end
    @(posedge clk); // packet moves on this edge
    io_link_i[col] <= '0;
  endtask

  task recv_pkt(input int col, output mesh_pkg::mesh_pkt_s pkt, output logic got);
    int waited;
    waited = 0;
    while (rx_q[col].size() == 0 && waited < wait_limit) begin
      @(negedge clk);
      waited++;
    end
    got = (rx_q[col].size() != 0);
    if (got) pkt = rx_q[col].pop_front();
    else begin
      $display("no response on column %0d within %0d cycles", col, wait_limit);
      errors++;
    end
  endtask

  task do_store(input int col, input int tx, input int ty, input mesh_pkg::addr_t addr,
                input mesh_pkg::data_t data);
    send_pkt(col, make_pkt(mesh_pkg::op_store, col, tx, ty, addr, data));
    ref_mem[mem_key(tx, ty, addr)] = data;
  endtask

  task check_load(input int col, input int tx, input int ty, input mesh_pkg::addr_t addr);
    mesh_pkg::mesh_pkt_s pkt;
    mesh_pkg::data_t     exp_data;
    logic                got;
    logic                known;
    recv_pkt(col, pkt, got);
    known    = ref_mem.exists(mem_key(tx, ty, addr));
    exp_data = known ? ref_mem[mem_key(tx, ty, addr)] : '0;
    if (got) begin
      assert (pkt.op == mesh_pkg::op_resp && pkt.addr == addr &&
              pkt.src_x == mesh_pkg::x_cord_t'(tx) && pkt.src_y == mesh_pkg::y_cord_t'(ty) &&
              pkt.dest_x == mesh_pkg::x_cord_t'(col) &&
              pkt.dest_y == mesh_pkg::y_cord_t'(mesh_pkg::io_row) &&
              (!known || pkt.data == exp_data))
      else begin
        $display("FAIL %0t: col %0d load tile (%0d,%0d) addr %h got op %0d src (%0d,%0d)",
                 $time, col, tx, ty, addr, pkt.op, pkt.src_x, pkt.src_y);
        $display("FAIL %0t:   dest (%0d,%0d) addr %h data %h, expected data %h", $time,
                 pkt.dest_x, pkt.dest_y, pkt.addr, pkt.data, exp_data);
        errors++;
      end
    end
  endtask

  task do_load(input int col, input int tx, input int ty, input mesh_pkg::addr_t addr);
    send_pkt(col, make_pkt(mesh_pkg::op_load, col, tx, ty, addr, '0));
    check_load(col, tx, ty, addr);
  endtask

  task check_idle(input int ncyc);
    repeat (ncyc) @(negedge clk);
    assert (rx_q[0].size() == 0 && rx_q[1].size() == 0)
    else begin
      $display("FAIL %0t: stray responses, %0d on column 0 and %0d on column 1", $time,
               rx_q[0].size(), rx_q[1].size());
      errors++;
    end
  endtask

  task report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  task test_reset;
    int e0;
    e0 = errors;
    @(negedge clk);
    assert (!io_link_o[0].valid && !io_link_o[1].valid && io_ready_o == '1)
    else begin
      $display("FAIL %0t: after reset valid %b%b ready %b", $time, io_link_o[1].valid,
               io_link_o[0].valid, io_ready_o);
      errors++;
    end
    report_test("reset state", e0);
  endtask

  task test_store_load;
    int e0;
    e0 = errors;
    for (int t = 0; t < 4; t++) begin
      do_store(0, t % nx, t / nx, mesh_pkg::addr_t'(8'h20 + 2 * t),
               mesh_pkg::data_t'(32'ha5a5_0000 + t * 32'h1111));
    end
    for (int t = 0; t < 4; t++) do_load(0, t % nx, t / nx, mesh_pkg::addr_t'(8'h20 + 2 * t));
    report_test("store then load back", e0);
  endtask

  task test_cross_column;
    int e0;
    e0 = errors;
    send_pkt(1, make_pkt(mesh_pkg::op_load, 1, 0, 0, 8'h20, '0));
    send_pkt(0, make_pkt(mesh_pkg::op_load, 0, 1, 1, 8'h26, '0));
    check_load(1, 0, 0, 8'h20);
    check_load(0, 1, 1, 8'h26);
    check_idle(10);
    report_test("cross-column return", e0);
  endtask

  task test_backpressure;
    int e0;
    e0 = errors;
    for (int k = 0; k < 4; k++) begin
      do_store(0, 1, 0, mesh_pkg::addr_t'(8'h40 + 2 * k), mesh_pkg::data_t'(32'h0bad_0000 + k));
    end
    @(posedge clk);
    io_ready_i[0] <= 1'b0;
    for (int k = 0; k < 4; k++) begin
      send_pkt(0, make_pkt(mesh_pkg::op_load, 0, 1, 0, mesh_pkg::addr_t'(8'h40 + 2 * k), '0));
    end
    repeat (20) @(negedge clk); // let the responses pile up
    assert (io_link_o[0].valid && rx_q[0].size() == 0)
    else begin
      $display("FAIL %0t: column 0 stalled but valid %b, %0d taken", $time,
               io_link_o[0].valid, rx_q[0].size());
      errors++;
    end
    @(posedge clk);
    io_ready_i[0] <= 1'b1;
    for (int k = 0; k < 4; k++) check_load(0, 1, 0, mesh_pkg::addr_t'(8'h40 + 2 * k));
    check_idle(10);
    report_test("back-pressure", e0);
  endtask

  task test_random;
    int              e0;
    int              col;
    int              tx;
    int              ty;
    mesh_pkg::addr_t addr;
    e0 = errors;
    for (int n = 0; n < num_random; n++) begin
      col  = $urandom_range(nx - 1, 0);
      tx   = $urandom_range(nx - 1, 0);
      ty   = $urandom_range(mesh_pkg::num_tiles_y - 1, 0);
      addr = mesh_pkg::addr_t'(($urandom_range(127, 0) << 1) | col); // parity owned by column
      if ($urandom_range(1, 0) == 1) do_store(col, tx, ty, addr, $urandom);
      else do_load(col, tx, ty, addr);
    end
    check_idle(10);
    report_test("random traffic", e0);
  endtask

  initial begin
    void'($urandom(67));
    arst_n_i   = 1'b0;
    io_link_i  = '0;
    io_ready_i = '1;
    repeat (3) @(posedge clk);
    arst_n_i <= 1'b1;
    test_reset();
    test_store_load();
    test_cross_column();
    test_backpressure();
    test_random();
    $display("tests ok %0d, tests with errors %0d", tests_passed, tests_failed);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
